// ==== Bender.yml ====
package:
  name: huff_encoder

sources:
  - files:
      - hw/huff_data_pkg.sv
      - hw/huff_ctrl_pkg.sv
      - hw/huff_symbol_counter.sv
      - hw/huff_sort_merge.sv
      - hw/huff_code_builder.sv
      - hw/huff_controller.sv
      - hw/huff_encoder_top.sv
  - target: test
    include_dirs:
      - verif
    files:
      - verif/huff_props.sv
      - verif/huff_tb.sv

// ==== build.f ====
+incdir+verif
hw/huff_data_pkg.sv
hw/huff_ctrl_pkg.sv
hw/huff_symbol_counter.sv
hw/huff_sort_merge.sv
hw/huff_code_builder.sv
hw/huff_controller.sv
hw/huff_encoder_top.sv
verif/huff_props.sv
verif/huff_tb.sv

// ==== hw/huff_code_builder.sv ====
`timescale 1ns/1ps

module huff_code_builder import huff_data_pkg::*; (
	input logic clk,
	input logic rst,
	input logic clear,
	input logic merge_en,
	input member_set_t pair_a,
	input member_set_t pair_b,
	output code_bank_t codes,
	output mask_bank_t masks
);

	code_bank_t new_bit;

	// Mask is a run of ones, so mask+1 is the next free code bit
	always_comb begin
		for (int i = 0; i < NUM_SYMBOLS; i++) begin
			new_bit[i] = code_t'(masks[i] + mask_t'(1));
		end
	end

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			codes <= '0;
			masks <= '0;
		end else if (clear) begin
			codes <= '0;
			masks <= '0;
		end else if (merge_en) begin
			for (int i = 0; i < NUM_SYMBOLS; i++) begin
				if (pair_a[i] || pair_b[i]) begin
					masks[i] <= {masks[i][CODE_W-2:0], 1'b1};
				end
				// Last entry takes a 1, the one before it keeps 0
				if (pair_b[i]) begin
					codes[i] <= codes[i] | new_bit[i];
				end
			end
		end
	end

endmodule

// ==== hw/huff_controller.sv ====
`timescale 1ns/1ps

module huff_controller import huff_data_pkg::*, huff_ctrl_pkg::*; (
	input logic clk,
	input logic rst,
	input logic gray_valid,
	input logic sort_done,
	output logic count_en,
	output logic clear,
	output logic sort_load,
	output logic merge_en,
	output logic cnt_valid,
	output logic code_valid,
	output slot_count_t live
);

	huff_state_e state;
	huff_state_e next_state;

	always_comb begin
		next_state = state;
		clear = 1'b0;
		count_en = 1'b0;
		sort_load = 1'b0;
		merge_en = 1'b0;
		case (state)
			IDLE: begin
				// First symbol of a run is counted into cleared counters
				if (gray_valid) begin
					clear = 1'b1;
					count_en = 1'b1;
					next_state = COUNT;
				end
			end
			COUNT: begin
				if (gray_valid) begin
					count_en = 1'b1;
				end else begin
					next_state = LOAD;
				end
			end
			LOAD: begin
				sort_load = 1'b1;
				next_state = SORT;
			end
			SORT: begin
				if (sort_done) begin
					next_state = MERGE;
				end
			end
			MERGE: begin
				merge_en = 1'b1;
				next_state = (live > LAST_MERGE_LIVE) ? SORT : DONE;
			end
			DONE: begin
				next_state = IDLE;
			end
			default: begin
				next_state = IDLE;
			end
		endcase
	end

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			state <= IDLE;
			live <= slot_count_t'(NUM_SYMBOLS);
			cnt_valid <= 1'b0;
			code_valid <= 1'b0;
		end else begin
			state <= next_state;
			// Registered pulses, one cycle behind LOAD and DONE
			cnt_valid <= (state == LOAD);
			code_valid <= (state == DONE);
			if (sort_load) begin
				live <= slot_count_t'(NUM_SYMBOLS);
			end else if (merge_en) begin
				live <= live - 3'd1;
			end
		end
	end

endmodule

// ==== hw/huff_ctrl_pkg.sv ====
package huff_ctrl_pkg;

	// Live sorter slots, 1 to 6
	typedef logic [2:0] slot_count_t;

	// Last merge happens with two slots left
	localparam slot_count_t LAST_MERGE_LIVE = 3'd2;

	typedef enum logic [2:0] {
		IDLE,
		COUNT,
		LOAD,
		SORT,
		MERGE,
		DONE
	} huff_state_e;

endpackage

// ==== hw/huff_data_pkg.sv ====
package huff_data_pkg;

	// Six source symbols, values 1 to 6
	localparam int NUM_SYMBOLS = 6;

	localparam int COUNT_W = 8;
	localparam int SYMBOL_W = 8;
	localparam int CODE_W = 8;

	typedef logic [COUNT_W-1:0] count_t;
	typedef logic [SYMBOL_W-1:0] symbol_t;

	// Bit i stands for symbol i+1
	typedef logic [NUM_SYMBOLS-1:0] member_set_t;

	// Codes and masks are right aligned
	typedef logic [CODE_W-1:0] code_t;
	typedef logic [CODE_W-1:0] mask_t;

	// Range of symbol values that get counted
	localparam symbol_t SYM_FIRST = 8'd1;
	localparam symbol_t SYM_LAST = 8'd6;

	// One sorter slot
	typedef struct packed {
		count_t weight;
		member_set_t members;
	} sort_entry_t;

	// Element i belongs to symbol i+1
	typedef count_t [NUM_SYMBOLS-1:0] count_bank_t;
	typedef code_t [NUM_SYMBOLS-1:0] code_bank_t;
	typedef mask_t [NUM_SYMBOLS-1:0] mask_bank_t;

endpackage

// ==== hw/huff_encoder_top.sv ====
`timescale 1ns/1ps

module huff_encoder_top import huff_data_pkg::*, huff_ctrl_pkg::*; (
	input logic clk,
	input logic rst,
	input logic gray_valid,
	input symbol_t gray_data,
	output logic cnt_valid,
	output count_bank_t counts,
	output logic code_valid,
	output code_bank_t codes,
	output mask_bank_t masks
);

	logic count_en;
	logic clear;
	logic sort_load;
	logic merge_en;
	logic sort_done;
	slot_count_t live;
	member_set_t pair_a;
	member_set_t pair_b;

	huff_controller u_ctrl (
		.clk        (clk),
		.rst        (rst),
		.gray_valid (gray_valid),
		.sort_done  (sort_done),
		.count_en   (count_en),
		.clear      (clear),
		.sort_load  (sort_load),
		.merge_en   (merge_en),
		.cnt_valid  (cnt_valid),
		.code_valid (code_valid),
		.live       (live)
	);

	// Counts feed the sorter and go straight out
	huff_symbol_counter u_counter (
		.clk      (clk),
		.rst      (rst),
		.clear    (clear),
		.count_en (count_en),
		.symbol   (gray_data),
		.counts   (counts)
	);

	huff_sort_merge u_sort (
		.clk       (clk),
		.rst       (rst),
		.load      (sort_load),
		.merge_en  (merge_en),
		.live      (live),
		.counts    (counts),
		.sort_done (sort_done),
		.pair_a    (pair_a),
		.pair_b    (pair_b)
	);

	huff_code_builder u_codes (
		.clk      (clk),
		.rst      (rst),
		.clear    (clear),
		.merge_en (merge_en),
		.pair_a   (pair_a),
		.pair_b   (pair_b),
		.codes    (codes),
		.masks    (masks)
	);

endmodule

// ==== hw/huff_sort_merge.sv ====
`timescale 1ns/1ps

module huff_sort_merge import huff_data_pkg::*, huff_ctrl_pkg::*; (
	input logic clk,
	input logic rst,
	input logic load,
	input logic merge_en,
	input slot_count_t live,
	input count_bank_t counts,
	output logic sort_done,
	output member_set_t pair_a,
	output member_set_t pair_b
);

	sort_entry_t slot [NUM_SYMBOLS];
	sort_entry_t round_slot [NUM_SYMBOLS];
	sort_entry_t merged;
	logic [NUM_SYMBOLS-2:0] in_order;
	logic phase;
	slot_count_t idx_a;
	slot_count_t idx_b;

	// One odd-even round, phase 0 on (0,1)(2,3)(4,5), phase 1 on (1,2)(3,4)
	always_comb begin
		for (int k = 0; k < NUM_SYMBOLS; k++) begin
			round_slot[k] = slot[k];
		end
		for (int k = 0; k < NUM_SYMBOLS - 1; k++) begin
			if ((k % 2) == int'(phase) && (k + 1) < int'(live)) begin
				// Equal weights stay put, keeps the sort stable
				if (slot[k].weight < slot[k+1].weight) begin
					round_slot[k] = slot[k+1];
					round_slot[k+1] = slot[k];
				end
			end
		end
	end

	// Sorted when no live neighbour pair is out of order
	always_comb begin
		for (int k = 0; k < NUM_SYMBOLS - 1; k++) begin
			in_order[k] = ((k + 1) >= int'(live)) || (slot[k].weight >= slot[k+1].weight);
		end
	end

	assign sort_done = &in_order;

	// Last two live slots, clamped when fewer than two remain
	assign idx_b = (live > 3'd1) ? live - 3'd1 : 3'd1;
	assign idx_a = idx_b - 3'd1;

	assign pair_a = slot[idx_a].members;
	assign pair_b = slot[idx_b].members;

	assign merged.weight = slot[idx_a].weight + slot[idx_b].weight;
	assign merged.members = pair_a | pair_b;

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			phase <= 1'b0;
		end else if (load || merge_en) begin
			phase <= 1'b0;
		end else begin
			phase <= ~phase;
		end
	end

	always_ff @(posedge clk) begin
		if (load) begin
			for (int k = 0; k < NUM_SYMBOLS; k++) begin
				slot[k].weight <= counts[k];
				slot[k].members <= member_set_t'(1) << k;
			end
		end else if (merge_en) begin
			// Slot idx_b drops out of the live range
			slot[idx_a] <= merged;
		end else begin
			for (int k = 0; k < NUM_SYMBOLS; k++) begin
				slot[k] <= round_slot[k];
			end
		end
	end

endmodule

// ==== hw/huff_symbol_counter.sv ====
`timescale 1ns/1ps

module huff_symbol_counter import huff_data_pkg::*; (
	input logic clk,
	input logic rst,
	input logic clear,
	input logic count_en,
	input symbol_t symbol,
	output count_bank_t counts
);

	count_bank_t next_counts;
	logic in_range;
	symbol_t sym_index;

	// Values outside 1..6 never hit a counter
	assign in_range = (symbol >= SYM_FIRST) && (symbol <= SYM_LAST);
	assign sym_index = symbol - SYM_FIRST;

	always_comb begin
		next_counts = clear ? '0 : counts;
		if (count_en && in_range) begin
			for (int i = 0; i < NUM_SYMBOLS; i++) begin
				if (sym_index == symbol_t'(i)) begin
					next_counts[i] = next_counts[i] + count_t'(1);
				end
			end
		end
	end

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			counts <= '0;
		end else if (clear || count_en) begin
			counts <= next_counts;
		end
	end

endmodule

// ==== verif/huff_props.sv ====
`timescale 1ns/1ps

module huff_props (
	input logic clk,
	input logic rst,
	input logic cnt_valid,
	input logic code_valid
);

	// Set by cnt_valid, cleared once code_valid closes the run
	logic counts_reported;

	// Number of assertion failures so far
	int assert_failures = 0;

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			counts_reported <= 1'b0;
		end else if (cnt_valid) begin
			counts_reported <= 1'b1;
		end else if (code_valid) begin
			counts_reported <= 1'b0;
		end
	end

	cnt_valid_pulse: assert property (@(posedge clk) disable iff (rst)
		cnt_valid |=> !cnt_valid)
		else begin
			$error("cnt_valid stayed high for more than one cycle");
			assert_failures++;
		end

	code_valid_pulse: assert property (@(posedge clk) disable iff (rst)
		code_valid |=> !code_valid)
		else begin
			$error("code_valid stayed high for more than one cycle");
			assert_failures++;
		end

	quiet_in_reset: assert property (@(posedge clk)
		rst |-> (!cnt_valid && !code_valid))
		else begin
			$error("Result pulse seen while reset is held");
			assert_failures++;
		end

	code_after_counts: assert property (@(posedge clk) disable iff (rst)
		code_valid |-> counts_reported)
		else begin
			$error("code_valid came before cnt_valid in this run");
			assert_failures++;
		end

endmodule

bind huff_encoder_top huff_props u_props (
	.clk        (clk),
	.rst        (rst),
	.cnt_valid  (cnt_valid),
	.code_valid (code_valid)
);

// ==== verif/huff_tb_tests.svh ====
task automatic reset_state();
	int start_errors;
	start_errors = error_count;
	check_counts("reset_state", '0, counts);
	check_codes("reset_state", '0, '0, codes, masks);
	report_test("reset_state", start_errors);
endtask

task automatic distinct_counts();
	int per_symbol [NUM_SYMBOLS];
	symbol_t stream [$];
	int start_errors;
	int r;
	int s;
	start_errors = error_count;
	per_symbol = '{3, 7, 1, 12, 5, 9};
	// Interleaved so the counters advance side by side
	for (r = 0; r < 12; r++) begin
		for (s = 0; s < NUM_SYMBOLS; s++) begin
			if (r < per_symbol[s]) begin
				stream.push_back(symbol_t'(s + 1));
			end
		end
	end
	encode_and_compare("distinct_counts", stream);
	report_test("distinct_counts", start_errors);
endtask

task automatic equal_counts();
	symbol_t stream [$];
	int start_errors;
	int r;
	int s;
	start_errors = error_count;
	// Every weight ties, so slot order decides each merge
	for (r = 0; r < 4; r++) begin
		for (s = 1; s <= NUM_SYMBOLS; s++) begin
			stream.push_back(symbol_t'(s));
		end
	end
	encode_and_compare("equal_counts", stream);
	report_test("equal_counts", start_errors);
endtask

task automatic ignored_values();
	symbol_t stream [$];
	int start_errors;
	start_errors = error_count;
	// Starts on an ignored value, which still opens the run
	stream = '{8'd0, 8'd3, 8'd7, 8'd1, 8'd255, 8'd6, 8'd8, 8'd2, 8'd128,
		8'd5, 8'd4, 8'd6, 8'd3, 8'd200, 8'd1, 8'd0, 8'd6, 8'd9, 8'd6};
	encode_and_compare("ignored_values", stream);
	report_test("ignored_values", start_errors);
endtask

task automatic missing_symbols();
	symbol_t stream [$];
	int start_errors;
	start_errors = error_count;
	// Symbols 1, 3 and 5 never show up
	stream = '{8'd2, 8'd6, 8'd4, 8'd6, 8'd2, 8'd6, 8'd2, 8'd6,
		8'd4, 8'd6, 8'd2, 8'd6, 8'd2, 8'd6};
	encode_and_compare("missing_symbols", stream);
	report_test("missing_symbols", start_errors);
endtask

task automatic random_stream(output symbol_t stream[$]);
	int len;
	int i;
	stream = {};
	len = $urandom_range(200, 20);
	for (i = 0; i < len; i++) begin
		// Mostly real symbols, the odd 0 or 7 mixed in
		stream.push_back(symbol_t'($urandom_range(7, 0)));
	end
endtask

task automatic back_to_back_runs();
	symbol_t first [$];
	symbol_t second [$];
	int start_errors;
	start_errors = error_count;
	random_stream(first);
	random_stream(second);
	// Second run starts right after code_valid of the first
	encode_and_compare("back_to_back_runs first", first);
	encode_and_compare("back_to_back_runs second", second);
	report_test("back_to_back_runs", start_errors);
endtask

// ==== verif/huff_tb.sv ====
`timescale 1ns/1ps

module huff_tb import huff_data_pkg::*; ();

	localparam int CNT_TIMEOUT = 10;
	localparam int CODE_TIMEOUT = 100;

	logic clk = 1'b1;
	logic rst = 1'b0;
	logic gray_valid = 1'b0;
	symbol_t gray_data = '0;
	logic cnt_valid;
	count_bank_t counts;
	logic code_valid;
	code_bank_t codes;
	mask_bank_t masks;

	int error_count = 0;
	int tests_run = 0;
	int tests_failed = 0;

	huff_encoder_top UUT (
		.clk        (clk),
		.rst        (rst),
		.gray_valid (gray_valid),
		.gray_data  (gray_data),
		.cnt_valid  (cnt_valid),
		.counts     (counts),
		.code_valid (code_valid),
		.codes      (codes),
		.masks      (masks)
	);

	initial begin
		forever #50 clk = ~clk;
	end

	task automatic check_counts(input string name, input count_bank_t expected,
		input count_bank_t actual);
		if (actual !== expected) begin
			$display("[FAIL] %s: counts expected %h actual %h", name, expected, actual);
			error_count++;
		end
	endtask

	task automatic check_codes(input string name, input code_bank_t exp_codes,
		input mask_bank_t exp_masks, input code_bank_t act_codes,
		input mask_bank_t act_masks);
		if (act_codes !== exp_codes) begin
			$display("[FAIL] %s: codes expected %h actual %h", name, exp_codes, act_codes);
			error_count++;
		end
		if (act_masks !== exp_masks) begin
			$display("[FAIL] %s: masks expected %h actual %h", name, exp_masks, act_masks);
			error_count++;
		end
	endtask

	task automatic report_test(input string name, input int start_errors);
		tests_run++;
		if (error_count == start_errors) begin
			$display("Test %s: ok", name);
		end else begin
			tests_failed++;
			$display("Test %s: %0d errors", name, error_count - start_errors);
		end
	endtask

	// Reference counts, only values 1 to 6 land in a counter
	function automatic count_bank_t count_stream(input symbol_t stream[$]);
		count_bank_t result;
		result = '0;
		foreach (stream[i]) begin
			if (stream[i] >= 1 && stream[i] <= NUM_SYMBOLS) begin
				result[int'(stream[i]) - 1] = result[int'(stream[i]) - 1] + count_t'(1);
			end
		end
		return result;
	endfunction

	// Reference Huffman build: stable descending sort, merge the last two
	task automatic build_reference_codes(input count_bank_t cnt,
		output code_bank_t exp_codes, output mask_bank_t exp_masks);
		count_t weight [NUM_SYMBOLS];
		member_set_t members [NUM_SYMBOLS];
		int len [NUM_SYMBOLS];
		count_t tmp_weight;
		member_set_t tmp_members;
		int n;
		int i;
		int j;
		int s;
		exp_codes = '0;
		exp_masks = '0;
		for (i = 0; i < NUM_SYMBOLS; i++) begin
			weight[i] = cnt[i];
			members[i] = member_set_t'(1) << i;
			len[i] = 0;
		end
		for (n = NUM_SYMBOLS; n > 1; n--) begin
			// Insertion sort, moves an entry only past strictly smaller ones
			for (i = 1; i < n; i++) begin
				j = i;
				while (j > 0 && weight[j-1] < weight[j]) begin
					tmp_weight = weight[j-1];
					tmp_members = members[j-1];
					weight[j-1] = weight[j];
					members[j-1] = members[j];
					weight[j] = tmp_weight;
					members[j] = tmp_members;
					j--;
				end
			end
			for (s = 0; s < NUM_SYMBOLS; s++) begin
				if (members[n-1][s]) begin
					exp_codes[s][len[s]] = 1'b1;
				end
				if (members[n-2][s] || members[n-1][s]) begin
					exp_masks[s][len[s]] = 1'b1;
					len[s]++;
				end
			end
			weight[n-2] = weight[n-2] + weight[n-1];
			members[n-2] = members[n-2] | members[n-1];
		end
	endtask

	task automatic send_stream(input symbol_t stream[$]);
		foreach (stream[i]) begin
			@(negedge clk);
			gray_valid = 1'b1;
			gray_data = stream[i];
		end
		@(negedge clk);
		gray_valid = 1'b0;
		gray_data = '0;
	endtask

	task automatic wait_pulse(input bit for_codes, input int limit, output bit seen);
		int cycles;
		string sig_name;
		seen = 1'b0;
		cycles = 0;
		sig_name = for_codes ? "code_valid" : "cnt_valid";
		while (!seen && cycles < limit) begin
			@(negedge clk);
			seen = for_codes ? code_valid : cnt_valid;
			cycles++;
		end
		if (!seen) begin
			$display("Timed out after %0d cycles waiting for %s", limit, sig_name);
			error_count++;
		end
	endtask

	task automatic encode_and_compare(input string name, input symbol_t stream[$]);
		count_bank_t exp_counts;
		code_bank_t exp_codes;
		mask_bank_t exp_masks;
		bit seen;
		exp_counts = count_stream(stream);
		build_reference_codes(exp_counts, exp_codes, exp_masks);
		send_stream(stream);
		wait_pulse(1'b0, CNT_TIMEOUT, seen);
		if (seen) begin
			check_counts(name, exp_counts, counts);
			wait_pulse(1'b1, CODE_TIMEOUT, seen);
			if (seen) begin
				check_codes(name, exp_codes, exp_masks, codes, masks);
			end
		end
	endtask

	`include "huff_tb_tests.svh"

	initial begin
		// Single seed for every random stream of the run
		void'($urandom(32'he12372a3));
		@(negedge clk);
		rst = 1'b1;
		repeat (10) begin
			@(negedge clk);
		end
		rst = 1'b0;
		reset_state();
		distinct_counts();
		equal_counts();
		ignored_values();
		missing_symbols();
		back_to_back_runs();
		$display("Done: %0d tests, %0d failed, %0d errors, %0d assertion failures",
			tests_run, tests_failed, error_count, UUT.u_props.assert_failures);
		if (error_count == 0 && UUT.u_props.assert_failures == 0) begin
			$display("All tests passed");
		end else begin
			$display("Some tests failed");
		end
		$finish;
	end

endmodule
